// File: source/io_settings.svh
// word width, IOT device codes and printer timing
`ifndef IO_SETTINGS_SVH
`define IO_SETTINGS_SVH

`define WORD_BITS 12

// six-bit IOT device codes, octal
`define DEV_INT 6'o00
`define DEV_KBD 6'o03
`define DEV_PRT 6'o04

// memory extension uses group 2, low digit picks the field
`define DEV_MEM_BASE 6'o20

// cycles from a print command to printer done
`define PRINT_DELAY 8

`endif

// File: source/io_pkg.sv
// shared types for the I/O side
// machine word and CPU major states

`include "io_settings.svh"

package io_pkg;

    // bit 0 is the most significant bit
    typedef logic [0:`WORD_BITS-1] word_t;

    typedef enum logic [4:0] {
        F0 = 5'd0,  // fetch
        F1 = 5'd1,
        F2 = 5'd2,
        F3 = 5'd3,
        D0 = 5'd4,  // defer
        D1 = 5'd5,
        D2 = 5'd6,
        D3 = 5'd7,
        E0 = 5'd8,  // execute
        E1 = 5'd9,
        E2 = 5'd10,
        E3 = 5'd11,
        H0 = 5'd12  // halt
    } major_state_t;

endpackage

// File: source/iot_bus_if.sv
// IOT request bus from io_mux to the devices
// with master and device modports

interface iot_bus_if import io_pkg::*; ();

    logic       iot_strobe;   // one cycle, F3 of an IOT
    logic [0:5] device_code;  // instruction bits 3 to 8
    logic [0:2] op;           // instruction bits 9 to 11
    word_t      ac;

    modport master (
        output iot_strobe,
        output device_code,
        output op,
        output ac
    );

    modport device (
        input iot_strobe,
        input device_code,
        input op,
        input ac
    );

endinterface

// File: source/io_mux.sv
// IOT strobe and request bus, device reply multiplexing
// and the front-panel bus display latch

module io_mux import io_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  major_state_t state,
    input  word_t        instruction,
    input  word_t        ac,
    iot_bus_if.master    bus,
    input  word_t        int_data,
    input  word_t        kbd_data_in,
    input  word_t        prt_data_in,
    input  word_t        mem_data,
    input  logic         int_skip,
    input  logic         kbd_skip,
    input  logic         prt_skip,
    input  logic         mem_skip,
    output logic         skip,
    output word_t        in_bus,
    output word_t        bus_display
);

    word_t lac;      // ac captured in F2
    word_t lin_bus;  // in_bus captured in F2

    // opcode 6 is IOT, strobe only in F3
    assign bus.iot_strobe  = (state == F3) && (instruction[0:2] == 3'o6);
    assign bus.device_code = instruction[3:8];
    assign bus.op          = instruction[9:11];
    assign bus.ac          = ac;

    // input word back to the CPU, decoded on the whole instruction
    always_comb begin
        casez (instruction)
            12'o6004:          in_bus = int_data;     // interrupt status
            12'o6034, 12'o6036: in_bus = kbd_data_in; // keyboard read
            12'o604?:          in_bus = prt_data_in;  // printer returns nothing
            12'o6214, 12'o6224: in_bus = mem_data;    // field reads
            default:           in_bus = '0;
        endcase
    end

    always_comb begin
        casez (instruction)
            12'o6000, 12'o6003: skip = int_skip;
            12'o603?:          skip = kbd_skip;
            12'o604?:          skip = prt_skip;
            12'o62??:          skip = mem_skip;
            default:           skip = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == F2) begin
            lac     <= ac;
            lin_bus <= in_bus;
        end
    end

    // display shows what moved over the bus on the last IOT
    always_ff @(posedge clk) begin
        if (reset) begin
            bus_display <= '0;
        end else if (state == F3) begin
            case (instruction)
                12'o6004, 12'o6036:           bus_display <= lin_bus;
                12'o6005, 12'o6044, 12'o6046: bus_display <= lac;
                default:                      bus_display <= bus_display;
            endcase
        end
    end

endmodule

// File: source/tty_keyboard.sv
// teletype keyboard, receive buffer and done flag
// with IOTs 6030 to 6036

`include "io_settings.svh"

module tty_keyboard import io_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    iot_bus_if.device  bus,
    input  logic [0:7] kbd_data,
    input  logic       kbd_strobe,
    output word_t      data,
    output logic       skip,
    output logic       flag
);

    logic [0:7] buffer;
    logic       selected;
    logic       clear_flag;

    assign selected = (bus.device_code == `DEV_KBD);

    // 6030, 6032 and 6036 all drop the flag
    always_comb begin
        clear_flag = 1'b0;
        if (bus.iot_strobe && selected) begin
            case (bus.op)
                3'o0, 3'o2, 3'o6: clear_flag = 1'b1;
                default:          clear_flag = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (kbd_strobe) begin
            buffer <= kbd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flag <= 1'b0;
        end else if (kbd_strobe) begin
            flag <= 1'b1;  // new character wins over a clear
        end else if (clear_flag) begin
            flag <= 1'b0;
        end
    end

    assign skip = selected && (bus.op == 3'o1) && flag;  // 6031
    assign data = {4'b0000, buffer};

endmodule

// File: source/tty_printer.sv
// teletype printer, output buffer, print timer and done flag
// with IOTs 6041 to 6046

`include "io_settings.svh"

module tty_printer import io_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    iot_bus_if.device  bus,
    output logic [0:7] prt_data,
    output logic       prt_strobe,
    output word_t      data,
    output logic       skip,
    output logic       flag
);

    localparam int CNT_BITS = $clog2(`PRINT_DELAY);

    logic                selected;
    logic                print_cmd;
    logic                clear_cmd;
    logic [CNT_BITS-1:0] count;  // zero when idle

    assign selected  = (bus.device_code == `DEV_PRT);
    assign print_cmd = bus.iot_strobe && selected && (bus.op == 3'o4 || bus.op == 3'o6);
    assign clear_cmd = bus.iot_strobe && selected && (bus.op == 3'o2 || bus.op == 3'o6);

    // character is ac bits 4 to 11
    always_ff @(posedge clk) begin
        if (print_cmd) begin
            prt_data <= bus.ac[4:11];
        end
    end

    // count runs PRINT_DELAY-1 down to 1, strobe and flag
    // register on the last step so both show PRINT_DELAY after the IOT
    always_ff @(posedge clk) begin
        if (reset) begin
            count      <= '0;
            prt_strobe <= 1'b0;
            flag       <= 1'b0;
        end else begin
            prt_strobe <= 1'b0;
            if (clear_cmd) begin
                flag <= 1'b0;
            end
            if (print_cmd) begin
                count <= CNT_BITS'(`PRINT_DELAY - 1);  // restart with new char
            end else if (count == CNT_BITS'(1)) begin
                count      <= '0;
                prt_strobe <= 1'b1;
                flag       <= 1'b1;
            end else if (count != '0) begin
                count <= count - 1'b1;
            end
        end
    end

    assign skip = selected && (bus.op == 3'o1) && flag;  // 6041
    assign data = '0;

endmodule

// File: source/interrupt_ctl.sv
// interrupt enable and request, processor IOTs 6000 to 6004

`include "io_settings.svh"

module interrupt_ctl import io_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    iot_bus_if.device bus,
    input  logic      kbd_flag,
    input  logic      prt_flag,
    output word_t     data,
    output logic      skip,
    output logic      irq
);

    logic enable;
    logic request;  // any device flag up
    logic selected;
    logic strobe;

    assign selected = (bus.device_code == `DEV_INT);
    assign strobe   = bus.iot_strobe && selected;
    assign request  = kbd_flag || prt_flag;

    always_ff @(posedge clk) begin
        if (reset) begin
            enable <= 1'b0;
        end else if (strobe) begin
            case (bus.op)
                3'o1:       enable <= 1'b1;  // ION
                3'o0, 3'o2: enable <= 1'b0;  // 6000 skips first, then clears
                default:    enable <= enable;
            endcase
        end
    end

    // skip is combinational so it is still valid in F3 before the clear
    always_comb begin
        skip = 1'b0;
        if (selected) begin
            case (bus.op)
                3'o0:    skip = enable;
                3'o3:    skip = request;
                default: skip = 1'b0;
            endcase
        end
    end

    assign irq = enable && request;

    // status word, request in bit 0 and enable in bit 4
    always_comb begin
        data    = '0;
        data[0] = request;
        data[4] = enable;
    end

endmodule

// File: source/mem_extension.sv
// memory extension, data-field and instruction-field registers
// IOTs 62N1 to 62N3, reads 6214 and 6224

`include "io_settings.svh"

module mem_extension import io_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    iot_bus_if.device  bus,
    output logic [0:2] data_field,
    output logic [0:2] inst_field,
    output word_t      data,
    output logic       skip
);

    logic       selected;
    logic [0:2] field;     // N from device code 2N
    logic       load_df;
    logic       load_if;

    assign selected = ((bus.device_code & 6'o70) == `DEV_MEM_BASE);
    assign field    = bus.device_code[3:5];

    // op 1 is CDF, op 2 is CIF, op 3 does both
    assign load_df = bus.iot_strobe && selected && (bus.op == 3'o1 || bus.op == 3'o3);
    assign load_if = bus.iot_strobe && selected && (bus.op == 3'o2 || bus.op == 3'o3);

    always_ff @(posedge clk) begin
        if (reset) begin
            data_field <= 3'o0;
            inst_field <= 3'o0;
        end else begin
            if (load_df) begin
                data_field <= field;
            end
            if (load_if) begin
                inst_field <= field;
            end
        end
    end

    // field read back lands in bits 6 to 8
    always_comb begin
        data = '0;
        if (selected && bus.op == 3'o4) begin
            case (field)
                3'o1:    data[6:8] = data_field;  // RDF
                3'o2:    data[6:8] = inst_field;  // RIF
                default: data      = '0;
            endcase
        end
    end

    assign skip = 1'b0;  // no skip IOTs in this group

endmodule

// File: source/pdp8_io_top.sv
// I/O side top level, io_mux plus keyboard, printer,
// interrupt controller and memory extension on one IOT bus

module pdp8_io_top import io_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  major_state_t state,
    input  word_t        instruction,
    input  word_t        ac,
    input  logic [0:7]   kbd_data,
    input  logic         kbd_strobe,
    output logic         skip,
    output word_t        in_bus,
    output word_t        bus_display,
    output logic [0:7]   prt_data,
    output logic         prt_strobe,
    output logic         irq,
    output logic [0:2]   data_field,
    output logic [0:2]   inst_field
);

    word_t int_data;
    word_t kbd_data_in;
    word_t prt_data_in;
    word_t mem_data;
    logic  int_skip;
    logic  kbd_skip;
    logic  prt_skip;
    logic  mem_skip;
    logic  kbd_flag;
    logic  prt_flag;

    iot_bus_if bus_i ();

    io_mux mux_i (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .instruction (instruction),
        .ac          (ac),
        .bus         (bus_i.master),
        .int_data    (int_data),
        .kbd_data_in (kbd_data_in),
        .prt_data_in (prt_data_in),
        .mem_data    (mem_data),
        .int_skip    (int_skip),
        .kbd_skip    (kbd_skip),
        .prt_skip    (prt_skip),
        .mem_skip    (mem_skip),
        .skip        (skip),
        .in_bus      (in_bus),
        .bus_display (bus_display)
    );

    tty_keyboard kbd_i (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus_i.device),
        .kbd_data   (kbd_data),
        .kbd_strobe (kbd_strobe),
        .data       (kbd_data_in),
        .skip       (kbd_skip),
        .flag       (kbd_flag)
    );

    tty_printer prt_i (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus_i.device),
        .prt_data   (prt_data),
        .prt_strobe (prt_strobe),
        .data       (prt_data_in),
        .skip       (prt_skip),
        .flag       (prt_flag)
    );

    interrupt_ctl int_i (
        .clk      (clk),
        .reset    (reset),
        .bus      (bus_i.device),
        .kbd_flag (kbd_flag),
        .prt_flag (prt_flag),
        .data     (int_data),
        .skip     (int_skip),
        .irq      (irq)
    );

    mem_extension mem_i (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus_i.device),
        .data_field (data_field),
        .inst_field (inst_field),
        .data       (mem_data),
        .skip       (mem_skip)
    );

endmodule

// File: testbench/io_tb_tasks.svh
// directed tests for the I/O side, instruction driver,
// keyboard typing helper and the compare task

task automatic check_value(input string name, input logic [11:0] actual,
                           input logic [11:0] expected);
    if (actual !== expected) begin
        $display("Error: %s is %h, expected %h", name, actual, expected);
        $display("sim failed");
        $fatal(1, "value mismatch on %s", name);
    end
endtask

// request and enable bits, bit 0 is the msb
function automatic logic [11:0] status_word(input logic req, input logic en);
    logic [11:0] w;
    w = '0;
    w[11 - 0] = req;
    w[11 - 4] = en;
    return w;
endfunction

task automatic step_state(input major_state_t st);
    @(posedge clk);
    #5;
    state = st;
endtask

// one instruction through F0 to F3, skip and in_bus sampled mid F3
task automatic issue_instruction(input logic [11:0] instr, input logic [11:0] ac_val);
    step_state(F0);
    instruction = instr;
    ac          = ac_val;
    step_state(F1);
    step_state(F2);
    step_state(F3);
    #20;
    sampled_skip   = skip;
    sampled_in_bus = in_bus;
    step_state(H0);  // strobe edge passed, IOT effects now visible
endtask

task automatic type_key(input logic [7:0] ch);
    @(posedge clk);
    #5;
    kbd_data   = ch;
    kbd_strobe = 1'b1;
    @(posedge clk);
    #5;
    kbd_strobe = 1'b0;
endtask

task automatic reset_values();
    check_value("skip", 12'(skip), 12'd0);
    check_value("prt_strobe", 12'(prt_strobe), 12'd0);
    check_value("irq", 12'(irq), 12'd0);
    check_value("data_field", 12'(data_field), 12'd0);
    check_value("inst_field", 12'(inst_field), 12'd0);
    check_value("bus_display", bus_display, 12'd0);
endtask

task automatic keyboard_read();
    logic [7:0] ch;
    ch = 8'($urandom);
    type_key(ch);
    issue_instruction(12'o6031, 12'o0000);  // KSF
    check_value("skip", 12'(sampled_skip), 12'd1);
    issue_instruction(12'o6034, 12'o0000);
    check_value("in_bus", sampled_in_bus, {4'b0000, ch});
    issue_instruction(12'o6036, 12'o0000);  // KRB, reads and clears
    check_value("in_bus", sampled_in_bus, {4'b0000, ch});
    check_value("bus_display", bus_display, {4'b0000, ch});
    issue_instruction(12'o6031, 12'o0000);
    check_value("skip", 12'(sampled_skip), 12'd0);
endtask

task automatic printer_output();
    logic [11:0] ac_val;
    ac_val = 12'($urandom);
    issue_instruction(12'o6046, ac_val);  // TLS
    check_value("prt_data", 12'(prt_data), {4'b0000, ac_val[7:0]});
    check_value("bus_display", bus_display, ac_val);
    // cycle k after the F3 cycle, strobe only in cycle PRINT_DELAY
    #5;
    for (int k = 1; k <= `PRINT_DELAY + 1; k++) begin
        check_value("prt_strobe", 12'(prt_strobe), 12'(k == `PRINT_DELAY));
        @(posedge clk);
        #10;
    end
    issue_instruction(12'o6041, 12'o0000);
    check_value("skip", 12'(sampled_skip), 12'd1);
    issue_instruction(12'o6042, 12'o0000);
    issue_instruction(12'o6041, 12'o0000);
    check_value("skip", 12'(sampled_skip), 12'd0);
endtask

task automatic interrupt_flow();
    logic [7:0] ch;
    ch = 8'($urandom);
    check_value("irq", 12'(irq), 12'd0);
    type_key(ch);  // keyboard flag up, enable still off
    check_value("irq", 12'(irq), 12'd0);
    issue_instruction(12'o6001, 12'o0000);  // ION
    check_value("irq", 12'(irq), 12'd1);
    issue_instruction(12'o6004, 12'o0000);
    check_value("in_bus", sampled_in_bus, status_word(1'b1, 1'b1));
    check_value("bus_display", bus_display, status_word(1'b1, 1'b1));
    issue_instruction(12'o6003, 12'o0000);
    check_value("skip", 12'(sampled_skip), 12'd1);
    issue_instruction(12'o6000, 12'o0000);
    check_value("skip", 12'(sampled_skip), 12'd1);
    check_value("irq", 12'(irq), 12'd0);
    issue_instruction(12'o6000, 12'o0000);  // enable already off
    check_value("skip", 12'(sampled_skip), 12'd0);
    issue_instruction(12'o6032, 12'o0000);
    issue_instruction(12'o6003, 12'o0000);
    check_value("skip", 12'(sampled_skip), 12'd0);
endtask

task automatic field_registers();
    logic [11:0] df_code;
    logic [11:0] if_code;
    for (int n = 0; n < 8; n++) begin
        // data field counts up and instruction field down so the reads differ
        df_code = 12'(n * 8);  // N sits in the third octal digit
        if_code = 12'((7 - n) * 8);
        issue_instruction(12'o6201 + df_code, 12'o0000);
        check_value("data_field", 12'(data_field), 12'(n));
        issue_instruction(12'o6202 + if_code, 12'o0000);
        check_value("inst_field", 12'(inst_field), 12'(7 - n));
        check_value("data_field", 12'(data_field), 12'(n));  // CIF leaves it alone
        issue_instruction(12'o6214, 12'o0000);
        check_value("in_bus", sampled_in_bus, 12'(n * 8));
        issue_instruction(12'o6224, 12'o0000);
        check_value("in_bus", sampled_in_bus, 12'((7 - n) * 8));
    end
endtask

task automatic unused_codes();
    logic [11:0] ac_val;
    ac_val = 12'($urandom);
    issue_instruction(12'o7201, ac_val);  // operate instruction with the CDF 0 bit pattern
    check_value("in_bus", sampled_in_bus, 12'd0);
    check_value("skip", 12'(sampled_skip), 12'd0);
    check_value("bus_display", bus_display, status_word(1'b1, 1'b1));  // last loaded by 6004
    issue_instruction(12'o6005, ac_val);
    check_value("in_bus", sampled_in_bus, 12'd0);
    check_value("skip", 12'(sampled_skip), 12'd0);
    check_value("bus_display", bus_display, ac_val);
    issue_instruction(12'o6101, 12'o7777);
    check_value("in_bus", sampled_in_bus, 12'd0);
    check_value("skip", 12'(sampled_skip), 12'd0);
    check_value("bus_display", bus_display, ac_val);
    check_value("data_field", 12'(data_field), 12'o7);  // left from the field test
    check_value("inst_field", 12'(inst_field), 12'o0);
    check_value("irq", 12'(irq), 12'd0);
    check_value("prt_strobe", 12'(prt_strobe), 12'd0);
endtask

// File: testbench/io_tb.sv
// testbench top for the I/O side, clock, reset, watchdog,
// DUT instance and the directed test sequence

`include "io_settings.svh"

module io_tb import io_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // 4 fetch states plus one idle cycle per instruction
    localparam int INSTR_COUNT    = 50;
    localparam int INSTR_CYCLES   = 5;
    localparam int TIMEOUT_CYCLES = 16 + INSTR_COUNT * INSTR_CYCLES
                                    + 2 * 2 + (`PRINT_DELAY + 1) + 100;

    logic         clk;
    logic         reset;
    major_state_t state;
    word_t        instruction;
    word_t        ac;
    logic [0:7]   kbd_data;
    logic         kbd_strobe;
    logic         skip;
    word_t        in_bus;
    word_t        bus_display;
    logic [0:7]   prt_data;
    logic         prt_strobe;
    logic         irq;
    logic [0:2]   data_field;
    logic [0:2]   inst_field;

    logic        sampled_skip;    // taken mid F3
    logic [11:0] sampled_in_bus;

    pdp8_io_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .instruction (instruction),
        .ac          (ac),
        .kbd_data    (kbd_data),
        .kbd_strobe  (kbd_strobe),
        .skip        (skip),
        .in_bus      (in_bus),
        .bus_display (bus_display),
        .prt_data    (prt_data),
        .prt_strobe  (prt_strobe),
        .irq         (irq),
        .data_field  (data_field),
        .inst_field  (inst_field)
    );

    `include "io_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'h8582_8620));
        reset          = 1'b1;
        state          = F0;
        instruction    = '0;  // AND 0, not an IOT
        ac             = '0;
        kbd_data       = '0;
        kbd_strobe     = 1'b0;
        sampled_skip   = 1'b0;
        sampled_in_bus = '0;
        repeat (16) @(posedge clk);
        #5;
        reset = 1'b0;

        reset_values();
        keyboard_read();
        printer_output();
        interrupt_flow();
        field_registers();
        unused_codes();

        $display("sim passed");
        $finish;
    end

endmodule

// File: files.f
+incdir+source
+incdir+testbench
source/io_pkg.sv
source/iot_bus_if.sv
source/io_mux.sv
source/tty_keyboard.sv
source/tty_printer.sv
source/interrupt_ctl.sv
source/mem_extension.sv
source/pdp8_io_top.sv
testbench/io_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the I/O testbench with Verilator, run it and check the log

LOG=sim.log
BIN=io_tb_sim

verilator --binary --timing --timescale 1ns/1ps \
    -f files.f --top-module io_tb -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^sim passed$" "$LOG"; then
    echo "result: ok"
    exit 0
else
    echo "result: pass line missing from $LOG"
    exit 1
fi
